//--- design/tlb_entry_pkg.sv
package tlb_entry_pkg;

    // entry count and index width
    localparam int tlb_num   = 16;
    localparam int tlb_idx_w = $clog2(tlb_num);

    // field widths of one entry
    localparam int vppn_w = 19;
    localparam int asid_w = 10;
    localparam int ppn_w  = 20;
    localparam int ps_w   = 6;
    localparam int plv_w  = 2;
    localparam int mat_w  = 2;

    // supported page sizes, log2 of the byte size
    localparam logic [ps_w-1:0] ps_4k = 6'd12;
    localparam logic [ps_w-1:0] ps_2m = 6'd21;

    // a 2 MB page ignores vppn bits below this one
    localparam int vppn_2m_lsb = 9;

endpackage

//--- design/tlb_cmd_pkg.sv
package tlb_cmd_pkg;

    localparam int invtlb_op_w = 5;

    // invtlb operation codes
    localparam logic [invtlb_op_w-1:0] inv_all0              = 5'd0;
    localparam logic [invtlb_op_w-1:0] inv_all1              = 5'd1;
    localparam logic [invtlb_op_w-1:0] inv_global            = 5'd2;
    localparam logic [invtlb_op_w-1:0] inv_nonglobal         = 5'd3;
    localparam logic [invtlb_op_w-1:0] inv_asid              = 5'd4;
    localparam logic [invtlb_op_w-1:0] inv_asid_va           = 5'd5;
    localparam logic [invtlb_op_w-1:0] inv_global_or_asid_va = 5'd6;

endpackage

//--- design/tlb_write_ctrl.sv
`timescale 1ns/100ps

module tlb_write_ctrl
    import tlb_entry_pkg::*;
    import tlb_cmd_pkg::*;
(
    input  logic                   we,
    input  logic [tlb_idx_w-1:0]   w_index,
    input  logic                   inv_valid,
    input  logic [invtlb_op_w-1:0] inv_op,
    output logic [tlb_num-1:0]     entry_we,
    output logic [tlb_num-1:0]     inv_en
);

    logic inv_op_ok;
    logic inv_go;

    // codes past op 6 are ignored
    assign inv_op_ok = (inv_op <= inv_global_or_asid_va);

    // a write in the same cycle blocks the invalidate
    assign inv_go = inv_valid & ~we & inv_op_ok;

    always_comb begin
        for (int i = 0; i < tlb_num; i++) begin
            entry_we[i] = we && (w_index == i[tlb_idx_w-1:0]);
            inv_en[i]   = inv_go;
        end
    end

endmodule

//--- design/tlb_entry.sv
`timescale 1ns/100ps

module tlb_entry
    import tlb_entry_pkg::*;
    import tlb_cmd_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    // write
    input  logic                   wr,
    input  logic                   w_e,
    input  logic [vppn_w-1:0]      w_vppn,
    input  logic [ps_w-1:0]        w_ps,
    input  logic [asid_w-1:0]      w_asid,
    input  logic                   w_g,
    input  logic [ppn_w-1:0]       w_ppn0,
    input  logic [plv_w-1:0]       w_plv0,
    input  logic [mat_w-1:0]       w_mat0,
    input  logic                   w_d0,
    input  logic                   w_v0,
    input  logic [ppn_w-1:0]       w_ppn1,
    input  logic [plv_w-1:0]       w_plv1,
    input  logic [mat_w-1:0]       w_mat1,
    input  logic                   w_d1,
    input  logic                   w_v1,
    // invalidate
    input  logic                   inv_en,
    input  logic [invtlb_op_w-1:0] inv_op,
    input  logic [asid_w-1:0]      inv_asid,
    input  logic [vppn_w-1:0]      inv_vppn,
    // search
    input  logic [vppn_w-1:0]      s_vppn,
    input  logic [asid_w-1:0]      s_asid,
    output logic                   hit,
    // stored fields
    output logic                   e,
    output logic [vppn_w-1:0]      vppn,
    output logic [ps_w-1:0]        ps,
    output logic [asid_w-1:0]      asid,
    output logic                   g,
    output logic [ppn_w-1:0]       ppn0,
    output logic [plv_w-1:0]       plv0,
    output logic [mat_w-1:0]       mat0,
    output logic                   d0,
    output logic                   v0,
    output logic [ppn_w-1:0]       ppn1,
    output logic [plv_w-1:0]       plv1,
    output logic [mat_w-1:0]       mat1,
    output logic                   d1,
    output logic                   v1
);

    logic is_2m;
    logic inv_asid_eq;
    logic inv_va_eq;
    logic inv_hit;

    // 2 MB pages skip the low vppn bits
    function automatic logic vppn_eq(input logic [vppn_w-1:0] a,
                                     input logic [vppn_w-1:0] b,
                                     input logic              big);
        if (big)
            return a[vppn_w-1:vppn_2m_lsb] == b[vppn_w-1:vppn_2m_lsb];
        return a == b;
    endfunction

    assign is_2m = (ps == ps_2m);
    assign hit   = e && (g || asid == s_asid) && vppn_eq(vppn, s_vppn, is_2m);

    assign inv_asid_eq = (asid == inv_asid);
    assign inv_va_eq   = vppn_eq(vppn, inv_vppn, is_2m);

    always_comb begin
        case (inv_op)
            inv_all0, inv_all1:    inv_hit = 1'b1;
            inv_global:            inv_hit = g;
            inv_nonglobal:         inv_hit = ~g;
            inv_asid:              inv_hit = ~g && inv_asid_eq;
            inv_asid_va:           inv_hit = ~g && inv_asid_eq && inv_va_eq;
            inv_global_or_asid_va: inv_hit = (g || inv_asid_eq) && inv_va_eq;
            default:               inv_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e <= 1'b0;
        end else if (wr) begin
            e <= w_e;
        end else if (inv_en && inv_hit) begin
            e <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            vppn <= w_vppn;
            ps   <= w_ps;
            asid <= w_asid;
            g    <= w_g;
            ppn0 <= w_ppn0;
            plv0 <= w_plv0;
            mat0 <= w_mat0;
            d0   <= w_d0;
            v0   <= w_v0;
            ppn1 <= w_ppn1;
            plv1 <= w_plv1;
            mat1 <= w_mat1;
            d1   <= w_d1;
            v1   <= w_v1;
        end
    end

endmodule

//--- design/tlb_lookup.sv
`timescale 1ns/100ps

module tlb_lookup
    import tlb_entry_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    // search request
    input  logic                              s_valid,
    output logic                              s_ready,
    input  logic [vppn_w-1:0]                 s_vppn,
    input  logic                              s_va_bit12,
    // search result
    output logic                              r_valid,
    input  logic                              r_ready,
    output logic                              r_found,
    output logic [tlb_idx_w-1:0]              r_index,
    output logic [ppn_w-1:0]                  r_ppn,
    output logic [ps_w-1:0]                   r_ps,
    output logic [plv_w-1:0]                  r_plv,
    output logic [mat_w-1:0]                  r_mat,
    output logic                              r_d,
    output logic                              r_v,
    // per entry
    input  logic [tlb_num-1:0]                hit,
    input  logic [tlb_num-1:0]                ent_e,
    input  logic [tlb_num-1:0][vppn_w-1:0]    ent_vppn,
    input  logic [tlb_num-1:0][ps_w-1:0]      ent_ps,
    input  logic [tlb_num-1:0][asid_w-1:0]    ent_asid,
    input  logic [tlb_num-1:0]                ent_g,
    input  logic [tlb_num-1:0][ppn_w-1:0]     ent_ppn0,
    input  logic [tlb_num-1:0][plv_w-1:0]     ent_plv0,
    input  logic [tlb_num-1:0][mat_w-1:0]     ent_mat0,
    input  logic [tlb_num-1:0]                ent_d0,
    input  logic [tlb_num-1:0]                ent_v0,
    input  logic [tlb_num-1:0][ppn_w-1:0]     ent_ppn1,
    input  logic [tlb_num-1:0][plv_w-1:0]     ent_plv1,
    input  logic [tlb_num-1:0][mat_w-1:0]     ent_mat1,
    input  logic [tlb_num-1:0]                ent_d1,
    input  logic [tlb_num-1:0]                ent_v1,
    // read port
    input  logic [tlb_idx_w-1:0]              rd_index,
    output logic                              rd_e,
    output logic [vppn_w-1:0]                 rd_vppn,
    output logic [ps_w-1:0]                   rd_ps,
    output logic [asid_w-1:0]                 rd_asid,
    output logic                              rd_g,
    output logic [ppn_w-1:0]                  rd_ppn0,
    output logic [plv_w-1:0]                  rd_plv0,
    output logic [mat_w-1:0]                  rd_mat0,
    output logic                              rd_d0,
    output logic                              rd_v0,
    output logic [ppn_w-1:0]                  rd_ppn1,
    output logic [plv_w-1:0]                  rd_plv1,
    output logic [mat_w-1:0]                  rd_mat1,
    output logic                              rd_d1,
    output logic                              rd_v1
);

    logic                 hit_any;
    logic [tlb_idx_w-1:0] hit_idx;
    logic                 s_odd;
    logic                 s_fire;
    logic [ppn_w-1:0]     sel_ppn;
    logic [ps_w-1:0]      sel_ps;
    logic [plv_w-1:0]     sel_plv;
    logic [mat_w-1:0]     sel_mat;
    logic                 sel_d;
    logic                 sel_v;

    // lowest index wins, so scan downwards
    always_comb begin
        hit_any = 1'b0;
        hit_idx = '0;
        for (int i = tlb_num - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_any = 1'b1;
                hit_idx = i[tlb_idx_w-1:0];
            end
        end
    end

    // 4k pages pick by va bit 12, 2M pages by vppn bit 8
    assign s_odd = (ent_ps[hit_idx] == ps_4k) ? s_va_bit12 : s_vppn[vppn_2m_lsb-1];

    always_comb begin
        sel_ppn = '0;
        sel_ps  = '0;
        sel_plv = '0;
        sel_mat = '0;
        sel_d   = 1'b0;
        sel_v   = 1'b0;
        if (hit_any) begin
            sel_ps  = ent_ps[hit_idx];
            sel_ppn = s_odd ? ent_ppn1[hit_idx] : ent_ppn0[hit_idx];
            sel_plv = s_odd ? ent_plv1[hit_idx] : ent_plv0[hit_idx];
            sel_mat = s_odd ? ent_mat1[hit_idx] : ent_mat0[hit_idx];
            sel_d   = s_odd ? ent_d1[hit_idx] : ent_d0[hit_idx];
            sel_v   = s_odd ? ent_v1[hit_idx] : ent_v0[hit_idx];
        end
    end

    // result slot frees up when empty or drained this cycle
    assign s_ready = ~r_valid | r_ready;
    assign s_fire  = s_valid & s_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
        end else if (s_ready) begin
            r_valid <= s_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s_fire) begin
            r_found <= hit_any;
            r_index <= hit_idx;
            r_ppn   <= sel_ppn;
            r_ps    <= sel_ps;
            r_plv   <= sel_plv;
            r_mat   <= sel_mat;
            r_d     <= sel_d;
            r_v     <= sel_v;
        end
    end

    assign rd_e    = ent_e[rd_index];
    assign rd_vppn = ent_vppn[rd_index];
    assign rd_ps   = ent_ps[rd_index];
    assign rd_asid = ent_asid[rd_index];
    assign rd_g    = ent_g[rd_index];
    assign rd_ppn0 = ent_ppn0[rd_index];
    assign rd_plv0 = ent_plv0[rd_index];
    assign rd_mat0 = ent_mat0[rd_index];
    assign rd_d0   = ent_d0[rd_index];
    assign rd_v0   = ent_v0[rd_index];
    assign rd_ppn1 = ent_ppn1[rd_index];
    assign rd_plv1 = ent_plv1[rd_index];
    assign rd_mat1 = ent_mat1[rd_index];
    assign rd_d1   = ent_d1[rd_index];
    assign rd_v1   = ent_v1[rd_index];

endmodule

//--- design/tlb.sv
`timescale 1ns/100ps

module tlb
    import tlb_entry_pkg::*;
    import tlb_cmd_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    // search
    input  logic                   s_valid,
    output logic                   s_ready,
    input  logic [vppn_w-1:0]      s_vppn,
    input  logic                   s_va_bit12,
    input  logic [asid_w-1:0]      s_asid,
    // search result
    output logic                   r_valid,
    input  logic                   r_ready,
    output logic                   r_found,
    output logic [tlb_idx_w-1:0]   r_index,
    output logic [ppn_w-1:0]       r_ppn,
    output logic [ps_w-1:0]        r_ps,
    output logic [plv_w-1:0]       r_plv,
    output logic [mat_w-1:0]       r_mat,
    output logic                   r_d,
    output logic                   r_v,
    // write, for tlbwr and tlbfill
    input  logic                   we,
    input  logic [tlb_idx_w-1:0]   w_index,
    input  logic                   w_e,
    input  logic [vppn_w-1:0]      w_vppn,
    input  logic [ps_w-1:0]        w_ps,
    input  logic [asid_w-1:0]      w_asid,
    input  logic                   w_g,
    input  logic [ppn_w-1:0]       w_ppn0,
    input  logic [plv_w-1:0]       w_plv0,
    input  logic [mat_w-1:0]       w_mat0,
    input  logic                   w_d0,
    input  logic                   w_v0,
    input  logic [ppn_w-1:0]       w_ppn1,
    input  logic [plv_w-1:0]       w_plv1,
    input  logic [mat_w-1:0]       w_mat1,
    input  logic                   w_d1,
    input  logic                   w_v1,
    // read, for tlbrd
    input  logic [tlb_idx_w-1:0]   rd_index,
    output logic                   rd_e,
    output logic [vppn_w-1:0]      rd_vppn,
    output logic [ps_w-1:0]        rd_ps,
    output logic [asid_w-1:0]      rd_asid,
    output logic                   rd_g,
    output logic [ppn_w-1:0]       rd_ppn0,
    output logic [plv_w-1:0]       rd_plv0,
    output logic [mat_w-1:0]       rd_mat0,
    output logic                   rd_d0,
    output logic                   rd_v0,
    output logic [ppn_w-1:0]       rd_ppn1,
    output logic [plv_w-1:0]       rd_plv1,
    output logic [mat_w-1:0]       rd_mat1,
    output logic                   rd_d1,
    output logic                   rd_v1,
    // invtlb
    input  logic                   inv_valid,
    input  logic [invtlb_op_w-1:0] inv_op,
    input  logic [asid_w-1:0]      inv_asid,
    input  logic [vppn_w-1:0]      inv_vppn
);

    logic [tlb_num-1:0]             entry_we;
    logic [tlb_num-1:0]             inv_en;
    logic [tlb_num-1:0]             hit;
    logic [tlb_num-1:0]             ent_e;
    logic [tlb_num-1:0][vppn_w-1:0] ent_vppn;
    logic [tlb_num-1:0][ps_w-1:0]   ent_ps;
    logic [tlb_num-1:0][asid_w-1:0] ent_asid;
    logic [tlb_num-1:0]             ent_g;
    logic [tlb_num-1:0][ppn_w-1:0]  ent_ppn0;
    logic [tlb_num-1:0][plv_w-1:0]  ent_plv0;
    logic [tlb_num-1:0][mat_w-1:0]  ent_mat0;
    logic [tlb_num-1:0]             ent_d0;
    logic [tlb_num-1:0]             ent_v0;
    logic [tlb_num-1:0][ppn_w-1:0]  ent_ppn1;
    logic [tlb_num-1:0][plv_w-1:0]  ent_plv1;
    logic [tlb_num-1:0][mat_w-1:0]  ent_mat1;
    logic [tlb_num-1:0]             ent_d1;
    logic [tlb_num-1:0]             ent_v1;

    tlb_write_ctrl u_write_ctrl (.*);

    for (genvar i = 0; i < tlb_num; i++) begin : g_entry
        tlb_entry u_entry (
            .wr     (entry_we[i]),
            .inv_en (inv_en[i]),
            .hit    (hit[i]),
            .e      (ent_e[i]),
            .vppn   (ent_vppn[i]),
            .ps     (ent_ps[i]),
            .asid   (ent_asid[i]),
            .g      (ent_g[i]),
            .ppn0   (ent_ppn0[i]),
            .plv0   (ent_plv0[i]),
            .mat0   (ent_mat0[i]),
            .d0     (ent_d0[i]),
            .v0     (ent_v0[i]),
            .ppn1   (ent_ppn1[i]),
            .plv1   (ent_plv1[i]),
            .mat1   (ent_mat1[i]),
            .d1     (ent_d1[i]),
            .v1     (ent_v1[i]),
            .*
        );
    end

    tlb_lookup u_lookup (.*);

endmodule

//--- dv/tlb_props.sv
`timescale 1ns/100ps

module tlb_props
    import tlb_entry_pkg::*;
(
    input logic                 clk,
    input logic                 rst_n,
    input logic                 s_ready,
    input logic                 r_valid,
    input logic                 r_ready,
    input logic                 r_found,
    input logic [tlb_idx_w-1:0] r_index,
    input logic [ppn_w-1:0]     r_ppn,
    input logic [ps_w-1:0]      r_ps,
    input logic [plv_w-1:0]     r_plv,
    input logic [mat_w-1:0]     r_mat,
    input logic                 r_d,
    input logic                 r_v
);

    logic [tlb_idx_w+ppn_w+ps_w+plv_w+mat_w+2:0] result;

    assign result = {r_found, r_index, r_ppn, r_ps, r_plv, r_mat, r_d, r_v};

    a_empty_after_reset: assert property (@(posedge clk) !rst_n |=> !r_valid)
        else $error("r_valid set right after reset");

    // stalled result must not move
    a_hold_result: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid && !r_ready |=> r_valid && $stable(result))
        else $error("result changed while stalled");

    a_ready_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !r_valid |-> s_ready)
        else $error("s_ready low with an empty result register");

endmodule

bind tlb tlb_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_ready (s_ready),
    .r_valid (r_valid),
    .r_ready (r_ready),
    .r_found (r_found),
    .r_index (r_index),
    .r_ppn   (r_ppn),
    .r_ps    (r_ps),
    .r_plv   (r_plv),
    .r_mat   (r_mat),
    .r_d     (r_d),
    .r_v     (r_v)
);

//--- dv/tlb_tb.sv
`timescale 1ns/100ps

module tlb_tb
    import tlb_entry_pkg::*;
    import tlb_cmd_pkg::*;
();

    // stimulus runs for roughly 600 cycles, limit leaves a wide margin
    localparam int max_cycles = 2000;

    localparam logic [asid_w-1:0] asid_a = 10'h0a5;
    localparam logic [asid_w-1:0] asid_b = 10'h15a;
    // same 2 MB region, differ in vppn bit 8
    localparam logic [vppn_w-1:0] vppn_a = 19'h2a4c1;
    localparam logic [vppn_w-1:0] vppn_b = 19'h2a5c1;

    typedef struct packed {
        logic              e;
        logic [vppn_w-1:0] vppn;
        logic [ps_w-1:0]   ps;
        logic [asid_w-1:0] asid;
        logic              g;
        logic [ppn_w-1:0]  ppn0;
        logic [plv_w-1:0]  plv0;
        logic [mat_w-1:0]  mat0;
        logic              d0;
        logic              v0;
        logic [ppn_w-1:0]  ppn1;
        logic [plv_w-1:0]  plv1;
        logic [mat_w-1:0]  mat1;
        logic              d1;
        logic              v1;
    } ent_t;

    typedef struct packed {
        logic                 found;
        logic [tlb_idx_w-1:0] index;
        logic [ppn_w-1:0]     ppn;
        logic [ps_w-1:0]      ps;
        logic [plv_w-1:0]     plv;
        logic [mat_w-1:0]     mat;
        logic                 d;
        logic                 v;
    } res_t;

    logic clk, rst_n, s_valid, s_ready, s_va_bit12, r_valid, r_ready, r_found, r_d, r_v;
    logic we, w_e, w_g, w_d0, w_v0, w_d1, w_v1, inv_valid;
    logic rd_e, rd_g, rd_d0, rd_v0, rd_d1, rd_v1;
    logic [vppn_w-1:0]      s_vppn, w_vppn, rd_vppn, inv_vppn;
    logic [asid_w-1:0]      s_asid, w_asid, rd_asid, inv_asid;
    logic [tlb_idx_w-1:0]   r_index, w_index, rd_index;
    logic [ppn_w-1:0]       r_ppn, w_ppn0, w_ppn1, rd_ppn0, rd_ppn1;
    logic [ps_w-1:0]        r_ps, w_ps, rd_ps;
    logic [plv_w-1:0]       r_plv, w_plv0, w_plv1, rd_plv0, rd_plv1;
    logic [mat_w-1:0]       r_mat, w_mat0, w_mat1, rd_mat0, rd_mat1;
    logic [invtlb_op_w-1:0] inv_op;

    integer             seed = 65304;
    int                 cycles = 0;
    int                 n_done = 0;
    logic               bp_on = 1'b0;
    ent_t               model [tlb_num];
    logic [tlb_num-1:0] written = '0;
    res_t               exp_q [$];

    tlb uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic value_error(input string what);
        stop_run($sformatf("CHECK FAILED at %0t ns: %s", $time, what));
    endtask

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic page_match(input ent_t m, input logic [vppn_w-1:0] va);
        logic [vppn_w-1:0] diff;
        diff = m.vppn ^ va;
        // a 2 MB page covers 512 small pages
        if (m.ps == ps_2m)
            diff = diff >> vppn_2m_lsb;
        return diff == '0;
    endfunction

    function automatic res_t predict(input logic [vppn_w-1:0] va, input logic bit12,
                                     input logic [asid_w-1:0] asid);
        res_t r;
        ent_t m;
        logic odd;
        r = '0;
        for (int i = 0; i < tlb_num; i++) begin
            m = model[i];
            if (!r.found && m.e && (m.g || m.asid == asid) && page_match(m, va)) begin
                odd = (m.ps == ps_2m) ? va[vppn_2m_lsb-1] : bit12;
                r.found = 1'b1;
                r.index = i[tlb_idx_w-1:0];
                r.ps    = m.ps;
                {r.ppn, r.plv, r.mat, r.d, r.v} = odd ? {m.ppn1, m.plv1, m.mat1, m.d1, m.v1}
                                                      : {m.ppn0, m.plv0, m.mat0, m.d0, m.v0};
            end
        end
        return r;
    endfunction

    function automatic logic inv_kills(input ent_t m, input logic [invtlb_op_w-1:0] op,
                                       input logic [asid_w-1:0] asid,
                                       input logic [vppn_w-1:0] va);
        logic same_asid;
        logic same_page;
        same_asid = (m.asid == asid);
        same_page = page_match(m, va);
        case (op)
            inv_all0, inv_all1:    return 1'b1;
            inv_global:            return m.g;
            inv_nonglobal:         return !m.g;
            inv_asid:              return !m.g && same_asid;
            inv_asid_va:           return !m.g && same_asid && same_page;
            inv_global_or_asid_va: return (m.g || same_asid) && same_page;
            default:               return 1'b0;
        endcase
    endfunction

    function automatic ent_t rand_entry();
        logic [95:0] bits;
        ent_t n;
        bits = {rand32(), rand32(), rand32()};
        n = bits[$bits(ent_t)-1:0];
        n.e = 1'b1;
        n.ps = bits[95] ? ps_2m : ps_4k;
        return n;
    endfunction

    // few asids and pages so invtlb has something to match
    function automatic ent_t pool_entry();
        ent_t n;
        logic [31:0] r;
        n = rand_entry();
        r = rand32();
        n.asid = r[0] ? asid_a : asid_b;
        n.vppn = r[1] ? vppn_a : vppn_b;
        n.g    = r[2];
        n.e    = r[3] | r[4];
        return n;
    endfunction

    task automatic step();
        logic [31:0] r;
        @(posedge clk);
        #1;
        r = rand32();
        r_ready = bp_on ? r[0] : 1'b1;
    endtask

    task automatic drive_fields(input ent_t ent);
        {w_e, w_vppn, w_ps, w_asid, w_g, w_ppn0, w_plv0, w_mat0, w_d0, w_v0,
         w_ppn1, w_plv1, w_mat1, w_d1, w_v1} = ent;
    endtask

    task automatic write_entry(input int idx, input ent_t ent);
        we = 1'b1;
        w_index = idx[tlb_idx_w-1:0];
        drive_fields(ent);
        step();
        we = 1'b0;
    endtask

    task automatic invalidate(input logic [invtlb_op_w-1:0] op);
        inv_valid = 1'b1;
        inv_op    = op;
        inv_asid  = asid_a;
        inv_vppn  = vppn_a;
        step();
        inv_valid = 1'b0;
    endtask

    task automatic search(input logic [vppn_w-1:0] va, input logic bit12,
                          input logic [asid_w-1:0] asid);
        logic taken;
        s_valid    = 1'b1;
        s_vppn     = va;
        s_va_bit12 = bit12;
        s_asid     = asid;
        do begin
            @(negedge clk);
            taken = s_ready;
            step();
        end while (!taken);
        s_valid = 1'b0;
    endtask

    // key taken from a model entry, asid sometimes wrong
    task automatic search_entry(input int k);
        logic [31:0] r;
        logic [vppn_w-1:0] va;
        r = rand32();
        va = model[k].vppn;
        if (model[k].ps == ps_2m)
            va[vppn_2m_lsb-1:0] = r[vppn_2m_lsb-1:0];
        search(va, r[12], r[13] ? model[k].asid : r[29:20]);
    endtask

    always @(posedge clk) begin : monitor
        ent_t rd_now;
        res_t got;
        res_t want;
        if (!rst_n) begin
            for (int i = 0; i < tlb_num; i++)
                model[i].e = 1'b0;
            exp_q.delete();
        end else begin
            rd_now = {rd_e, rd_vppn, rd_ps, rd_asid, rd_g, rd_ppn0, rd_plv0, rd_mat0, rd_d0,
                      rd_v0, rd_ppn1, rd_plv1, rd_mat1, rd_d1, rd_v1};
            assert (rd_now === model[rd_index] || (!written[rd_index] && rd_e === 1'b0))
                else value_error($sformatf("read port %0d gave %h, expected %h",
                                           rd_index, rd_now, model[rd_index]));
            if (r_valid && r_ready) begin
                assert (exp_q.size() > 0)
                    else stop_run("a search result came out with no search pending");
                got  = {r_found, r_index, r_ppn, r_ps, r_plv, r_mat, r_d, r_v};
                want = exp_q.pop_front();
                n_done++;
                assert (got === want)
                    else value_error($sformatf("result %0d was %h, expected %h",
                                               n_done, got, want));
            end
            if (s_valid && s_ready) begin
                exp_q.push_back(predict(s_vppn, s_va_bit12, s_asid));
            end
            // write or invtlb lands on this edge
            if (we) begin
                model[w_index] = {w_e, w_vppn, w_ps, w_asid, w_g, w_ppn0, w_plv0, w_mat0,
                                  w_d0, w_v0, w_ppn1, w_plv1, w_mat1, w_d1, w_v1};
                written[w_index] = 1'b1;
            end else if (inv_valid) begin
                for (int i = 0; i < tlb_num; i++)
                    if (inv_kills(model[i], inv_op, inv_asid, inv_vppn))
                        model[i].e = 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) s_valid && s_ready |=> r_valid)
        else value_error("no result one cycle after an accepted search");

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles)
            stop_run($sformatf("timeout: run still busy after %0d cycles", max_cycles));
    end

    initial begin
        ent_t ent;
        logic [31:0] r;
        logic [invtlb_op_w-1:0] ops [9];
        ops = '{inv_all0, inv_all1, inv_global, inv_nonglobal, inv_asid, inv_asid_va,
                inv_global_or_asid_va, 5'd7, 5'd31};
        rst_n = 1'b0;
        s_valid = 1'b0;
        s_vppn = '0;
        s_va_bit12 = 1'b0;
        s_asid = '0;
        r_ready = 1'b1;
        we = 1'b0;
        w_index = '0;
        drive_fields('0);
        rd_index = '0;
        inv_valid = 1'b0;
        inv_op = '0;
        inv_asid = '0;
        inv_vppn = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < tlb_num; i++)
            write_entry(i, rand_entry());
        for (int i = 0; i < tlb_num; i++) begin
            rd_index = i[tlb_idx_w-1:0];
            step();
        end

        // 4k page, own asid, wrong asid, then global
        ent = rand_entry();
        ent.ps   = ps_4k;
        ent.g    = 1'b0;
        ent.asid = 10'h155;
        ent.vppn = 19'h12345;
        write_entry(3, ent);
        search(19'h12345, 1'b0, 10'h155);
        search(19'h12345, 1'b1, 10'h155);
        search(19'h12345, 1'b0, 10'h2aa);
        ent.g = 1'b1;
        write_entry(3, ent);
        search(19'h12345, 1'b1, 10'h2aa);

        // 2M page picks its half by vppn bit 8, lower index wins
        ent.ps   = ps_2m;
        ent.vppn = 19'h6a000;
        write_entry(9, ent);
        search(19'h6a0c3, 1'b1, 10'h0);
        search(19'h6a1c3, 1'b0, 10'h0);
        write_entry(5, ent);
        search(19'h6a1ff, 1'b0, 10'h0);
        ent.ps   = ps_4k;
        ent.vppn = 19'h6a1ff;
        write_entry(2, ent);
        search(19'h6a1ff, 1'b1, 10'h0);
        for (int n = 0; n < 24; n++) begin
            r = rand32();
            search_entry(int'(r[3:0]));
        end

        foreach (ops[k]) begin
            for (int i = 0; i < tlb_num; i++)
                write_entry(i, pool_entry());
            invalidate(ops[k]);
            for (int i = 0; i < tlb_num; i++) begin
                rd_index = i[tlb_idx_w-1:0];
                search_entry(i);
            end
        end

        // write and invtlb together, only the write lands
        we = 1'b1;
        w_index = 4'd7;
        drive_fields(pool_entry());
        inv_valid = 1'b1;
        inv_op = inv_all0;
        step();
        we = 1'b0;
        inv_valid = 1'b0;
        rd_index = 4'd7;
        search_entry(7);

        bp_on = 1'b1;
        for (int n = 0; n < 60; n++) begin
            r = rand32();
            search_entry(int'(r[3:0]));
        end
        bp_on = 1'b0;
        while (exp_q.size() != 0)
            step();

        $display("Verification passed");
        $finish;
    end

endmodule

//--- tb.f
design/tlb_entry_pkg.sv
design/tlb_cmd_pkg.sv
design/tlb_write_ctrl.sv
design/tlb_entry.sv
design/tlb_lookup.sv
design/tlb.sv
dv/tlb_props.sv
dv/tlb_tb.sv

//--- run.sh
#!/usr/bin/env bash
# exit status follows the simulation result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tlb_tb -f tb.f -o tlb_sim &&
./obj_dir/tlb_sim ||
{ echo "simulation did not pass" >&2; exit 1; }
